// ==== sim.f ====
design/c16_mem_pkg.sv
design/mem_wr_if.sv
design/cpu_acc_if.sv
design/prg_loader.sv
design/rom_bank_ctrl.sv
design/c16_mem_store.sv
design/c16_mem_top.sv
dv/c16_mem_props.sv
dv/c16_mem_tb.sv

// ==== dv/c16_mem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Testbench for the C16/Plus 4 memory core
// Random downloads and CPU traffic checked
// against a reference model
//////////////////////////////

module c16_mem_tb
	import c16_mem_pkg::*;
();

	logic                clk_sys;
	logic                reset;
	logic                plus4_i;
	logic                dl_active_i;
	logic [DL_IDX_W-1:0] dl_index_i;
	logic                dl_wr_i;
	dl_addr_t            dl_addr_i;
	byte_t               dl_data_i;
	logic                dl_busy_o;
	logic                cpu_stb_i;
	logic                cpu_rnw_i;
	cpu_sel_t            cpu_sel_i;
	cpu_addr_t           cpu_addr_i;
	byte_t               cpu_wdata_i;
	byte_t               cpu_rdata_o;
	logic                cpu_rvalid_o;

	integer seed;

	// Reference model state, memories keyed by address
	byte_t      ram_m [int];
	byte_t      rom_m [int];
	int         rom_offs [$];
	logic       m_plus4;
	logic       m_cart_lo;
	logic       m_cart_hi;
	logic [1:0] m_lo_sel;
	logic [1:0] m_hi_sel;

	always #10 clk_sys = ~clk_sys;

	c16_mem_top u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.plus4_i      (plus4_i),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.dl_busy_o    (dl_busy_o),
		.cpu_stb_i    (cpu_stb_i),
		.cpu_rnw_i    (cpu_rnw_i),
		.cpu_sel_i    (cpu_sel_i),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_wdata_i  (cpu_wdata_i),
		.cpu_rdata_o  (cpu_rdata_o),
		.cpu_rvalid_o (cpu_rvalid_o)
	);

	//////////////////////////////
	// Failure reporting and compares
	//////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("** Error at %0t: cpu_rdata_o expected %02h, actual %02h (%s)",
				$time, exp, act, what);
			abort_run("read data mismatch");
		end
	endtask

	task automatic check_busy(input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error at %0t: dl_busy_o expected %0b, actual %0b", $time, exp, act);
			abort_run("busy flag mismatch");
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic void clear_model(input logic plus4);
		m_plus4   = plus4;
		m_lo_sel  = 2'd0;
		m_hi_sel  = 2'd0;
		m_cart_lo = 1'b0;
		m_cart_hi = 1'b0;
	endfunction

	// Download slot to ROM bank
	function automatic mem_src_t slot_src(input logic [DL_IDX_W-1:0] idx, input int slot);
		if (idx == DL_IDX_CART)
			return (slot == 0) ? SRC_CART_LO : (slot == 1) ? SRC_CART_HI : SRC_NONE;
		case (slot)
			1: return SRC_KERNAL;
			2: return SRC_BASIC;
			3: return SRC_FUNC_LO;
			4: return SRC_FUNC_HI;
			default: return SRC_NONE;
		endcase
	endfunction

	function automatic mem_src_t model_src(input cpu_sel_t sel, input cpu_addr_t addr);
		case (sel)
			SEL_RAM: return SRC_RAM;
			SEL_CS0: begin
				case (m_lo_sel)
					2'd0: return SRC_BASIC;
					2'd1: return SRC_CART_LO;
					2'd2: return SRC_FUNC_LO;
					default: return SRC_NONE;
				endcase
			end
			SEL_CS1: begin
				if (addr[15:8] == KERNAL_PAGE || m_hi_sel == 2'd0)
					return SRC_KERNAL;
				case (m_hi_sel)
					2'd1: return SRC_CART_HI;
					2'd2: return SRC_FUNC_HI;
					default: return SRC_NONE;
				endcase
			end
			default: return SRC_NONE;
		endcase
	endfunction

	function automatic byte_t model_read(input cpu_sel_t sel, input cpu_addr_t addr);
		mem_src_t src;
		src = model_src(sel, addr);
		if (src == SRC_RAM)
			return ram_m[int'(addr)];
		if (src == SRC_NONE)
			return OPEN_BUS;
		// Cartridge bank without an image floats
		if ((src == SRC_CART_LO && !m_cart_lo) || (src == SRC_CART_HI && !m_cart_hi))
			return OPEN_BUS;
		return rom_m[int'(src) * ROM_DEPTH + int'(addr[ROM_AW-1:0])];
	endfunction

	//////////////////////////////
	// Bus drivers
	//////////////////////////////
	task automatic cpu_write(input cpu_sel_t sel, input cpu_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		cpu_stb_i   <= 1'b1;
		cpu_rnw_i   <= 1'b0;
		cpu_sel_i   <= sel;
		cpu_addr_i  <= addr;
		cpu_wdata_i <= data;
		@(posedge clk_sys);
		cpu_stb_i   <= 1'b0;
		if (sel == SEL_RAM)
			ram_m[int'(addr)] = data;
		if (m_plus4 && sel == SEL_IO && addr[15:4] == BANK_REG_PAGE) begin
			m_hi_sel = addr[3:2];
			m_lo_sel = addr[1:0];
		end
	endtask

	task automatic cpu_read(input cpu_sel_t sel, input cpu_addr_t addr, output byte_t data);
		int n;
		@(posedge clk_sys);
		cpu_stb_i  <= 1'b1;
		cpu_rnw_i  <= 1'b1;
		cpu_sel_i  <= sel;
		cpu_addr_i <= addr;
		@(posedge clk_sys);
		cpu_stb_i  <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (cpu_rvalid_o !== 1'b1) begin
			n++;
			if (n > 8)
				abort_run($sformatf("timeout waiting for cpu_rvalid_o, addr %04h", addr));
			@(negedge clk_sys);
		end
		data = cpu_rdata_o;
	endtask

	task automatic read_and_check(input cpu_sel_t sel, input cpu_addr_t addr);
		byte_t exp;
		byte_t act;
		exp = model_read(sel, addr);
		cpu_read(sel, addr, act);
		check_byte($sformatf("sel %0d addr %04h", sel, addr), exp, act);
	endtask

	task automatic dl_open(input logic [DL_IDX_W-1:0] idx);
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i  <= idx;
		dl_wr_i     <= 1'b0;
	endtask

	task automatic dl_put(input dl_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= addr;
		dl_data_i <= data;
	endtask

	// Idle cycles let the last registered write land
	task automatic dl_close();
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (dl_busy_o !== level) begin
			n++;
			if (n > 40)
				abort_run($sformatf("timeout waiting for dl_busy_o to reach %0b", level));
			@(negedge clk_sys);
		end
	endtask

	task automatic do_reset(input logic plus4);
		@(posedge clk_sys);
		reset   <= 1'b1;
		plus4_i <= plus4;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		clear_model(plus4);
		@(negedge clk_sys);
		check_busy(1'b0, dl_busy_o);
	endtask

	//////////////////////////////
	// Test phases
	//////////////////////////////
	task automatic program_load();
		cpu_addr_t load;
		cpu_addr_t end_addr;
		byte_t     d;
		int        n;
		load = cpu_addr_t'(rand_range('h1000, 'h8FFF));
		n    = rand_range(20, 60);
		dl_open(DL_IDX_PRG);
		dl_put(dl_addr_t'(0), load[7:0]);
		dl_put(dl_addr_t'(1), load[15:8]);
		for (int i = 0; i < n; i++) begin
			d = byte_t'($random(seed));
			dl_put(dl_addr_t'(i + 2), d);
			ram_m[int'(load) + i] = d;
		end
		dl_close();
		wait_busy(1'b1);
		wait_busy(1'b0);
		// Pointers hold the end address, low byte first
		end_addr = load + cpu_addr_t'(n);
		for (int i = 0; i < 8; i++)
			ram_m[int'(PRG_PTR_ADDR[i])] = i[0] ? end_addr[15:8] : end_addr[7:0];
		for (int i = 0; i < n; i++)
			read_and_check(SEL_RAM, load + cpu_addr_t'(i));
		for (int i = 0; i < 8; i++)
			read_and_check(SEL_RAM, PRG_PTR_ADDR[i]);
	endtask

	task automatic rom_load();
		int       off;
		byte_t    d;
		mem_src_t src;
		rom_offs.delete();
		dl_open(DL_IDX_ROM);
		for (int k = 0; k < 24; k++) begin
			// First offset sits in the kernal page
			off = (k == 0) ? 'h3C00 + rand_range(0, 255) : rand_range(0, ROM_DEPTH - 1);
			rom_offs.push_back(off);
			for (int s = 1; s <= 4; s++) begin
				d   = byte_t'($random(seed));
				src = slot_src(DL_IDX_ROM, s);
				dl_put(dl_addr_t'(s * ROM_DEPTH + off), d);
				rom_m[int'(src) * ROM_DEPTH + off] = d;
			end
			dl_put(dl_addr_t'(off), ~d);
		end
		dl_close();
		@(negedge clk_sys);
		check_busy(1'b0, dl_busy_o);
	endtask

	task automatic window_reads(input int count);
		int       off;
		cpu_sel_t sel;
		for (int k = 0; k < count; k++) begin
			off = rom_offs[rand_range(0, rom_offs.size() - 1)];
			sel = cpu_sel_t'(rand_range(1, 3));
			case (sel)
				SEL_CS0: read_and_check(sel, 16'h8000 | cpu_addr_t'(off));
				SEL_CS1: read_and_check(sel, 16'hC000 | cpu_addr_t'(off));
				default: read_and_check(sel, cpu_addr_t'($random(seed)));
			endcase
		end
		read_and_check(SEL_CS1, 16'hC000 | cpu_addr_t'(rom_offs[0]));
	endtask

	task automatic plus4_banking();
		do_reset(1'b1);
		for (int k = 0; k < 40; k++) begin
			cpu_write(SEL_IO, {BANK_REG_PAGE, 4'(rand_range(0, 15))}, byte_t'($random(seed)));
			window_reads(4);
		end
	endtask

	task automatic cart_reads();
		cpu_write(SEL_IO, 16'hFDD5, 8'h00);
		foreach (rom_offs[k]) begin
			read_and_check(SEL_CS0, 16'h8000 | cpu_addr_t'(rom_offs[k]));
			read_and_check(SEL_CS1, 16'hC000 | cpu_addr_t'(rom_offs[k]));
		end
	endtask

	task automatic cart_check();
		byte_t d;
		dl_open(DL_IDX_CART);
		foreach (rom_offs[k]) begin
			for (int s = 0; s < 2; s++) begin
				d = byte_t'($random(seed));
				dl_put(dl_addr_t'(s * ROM_DEPTH + rom_offs[k]), d);
				rom_m[int'(slot_src(DL_IDX_CART, s)) * ROM_DEPTH + rom_offs[k]] = d;
			end
		end
		dl_close();
		m_cart_lo = 1'b1;
		m_cart_hi = 1'b1;
		cart_reads();
		// Reset clears both present flags
		do_reset(1'b1);
		cart_reads();
	endtask

	task automatic c16_banking();
		do_reset(1'b0);
		for (int k = 0; k < 20; k++) begin
			cpu_write(SEL_IO, {BANK_REG_PAGE, 4'(rand_range(0, 15))}, byte_t'($random(seed)));
			window_reads(3);
		end
	endtask

	task automatic ram_traffic();
		cpu_addr_t addr;
		int        op;
		for (int k = 0; k < 300; k++) begin
			addr = 16'hA000 | cpu_addr_t'(rand_range(0, 255));
			op   = rand_range(0, 3);
			if (op == 0)
				cpu_write(cpu_sel_t'(rand_range(1, 3)), addr, byte_t'($random(seed)));
			else if (op < 3 && ram_m.exists(int'(addr)))
				read_and_check(SEL_RAM, addr);
			else
				cpu_write(SEL_RAM, addr, byte_t'($random(seed)));
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		seed        = 32'h4181_1534;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		plus4_i     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = DL_IDX_ROM;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		cpu_stb_i   = 1'b0;
		cpu_rnw_i   = 1'b1;
		cpu_sel_i   = SEL_RAM;
		cpu_addr_i  = '0;
		cpu_wdata_i = '0;
		clear_model(1'b0);
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_busy(1'b0, dl_busy_o);

		program_load();
		rom_load();
		window_reads(40);
		plus4_banking();
		cart_check();
		c16_banking();
		ram_traffic();

		repeat (2) @(posedge clk_sys);
		if (u_dut.u_props.fail_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run($sformatf("%0d concurrent assertion failures",
				u_dut.u_props.fail_count));
		end
	end

endmodule

`default_nettype wire

// ==== dv/c16_mem_props.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Port checks for the memory core
// Read valid timing, reset state, busy length
//////////////////////////////

module c16_mem_props (
	input wire clk_sys,
	input wire reset,
	input wire cpu_stb_i,
	input wire cpu_rnw_i,
	input wire cpu_rvalid_o,
	input wire dl_busy_o
);

	int fail_count = 0;

	// Valid exactly one cycle after each read strobe, never otherwise
	rvalid_follows_read: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rvalid_o == $past(cpu_stb_i & cpu_rnw_i & ~reset))
	else begin
		fail_count++;
		$error("cpu_rvalid_o does not match the read strobe one cycle earlier");
	end

	idle_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (!cpu_rvalid_o && !dl_busy_o))
	else begin
		fail_count++;
		$error("cpu_rvalid_o or dl_busy_o high on the cycle after reset");
	end

	// Pointer patch keeps busy up for 16 cycles
	busy_length: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(dl_busy_o) |-> dl_busy_o [*16] ##1 !dl_busy_o)
	else begin
		fail_count++;
		$error("dl_busy_o was not high for exactly 16 cycles");
	end

endmodule

bind c16_mem_top c16_mem_props u_props (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.cpu_stb_i    (cpu_stb_i),
	.cpu_rnw_i    (cpu_rnw_i),
	.cpu_rvalid_o (cpu_rvalid_o),
	.dl_busy_o    (dl_busy_o)
);

`default_nettype wire

// ==== design/c16_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// C16/Plus 4 memory core top level
//////////////////////////////

module c16_mem_top
	import c16_mem_pkg::*;
(
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                plus4_i,

	// Download stream
	input  wire                dl_active_i,
	input  wire [DL_IDX_W-1:0] dl_index_i,
	input  wire                dl_wr_i,
	input  wire dl_addr_t      dl_addr_i,
	input  wire byte_t         dl_data_i,
	output logic               dl_busy_o,

	// CPU bus
	input  wire                cpu_stb_i,
	input  wire                cpu_rnw_i,
	input  wire cpu_sel_t      cpu_sel_i,
	input  wire cpu_addr_t     cpu_addr_i,
	input  wire byte_t         cpu_wdata_i,
	output byte_t              cpu_rdata_o,
	output logic               cpu_rvalid_o
);

	mem_wr_if  u_wr_if ();
	cpu_acc_if u_acc_if ();

	prg_loader u_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_busy_o   (dl_busy_o),
		.wr_o        (u_wr_if.driver)
	);

	rom_bank_ctrl u_bank_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.plus4_i     (plus4_i),
		.cpu_stb_i   (cpu_stb_i),
		.cpu_rnw_i   (cpu_rnw_i),
		.cpu_sel_i   (cpu_sel_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.acc_o       (u_acc_if.driver)
	);

	c16_mem_store u_store (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_i         (u_wr_if.store),
		.acc_i        (u_acc_if.store),
		.cpu_rdata_o  (cpu_rdata_o),
		.cpu_rvalid_o (cpu_rvalid_o)
	);

endmodule

`default_nettype wire

// ==== design/c16_mem_store.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Main RAM, six ROM banks and cartridge flags
// Loader and CPU write ports, registered CPU read
//////////////////////////////

module c16_mem_store
	import c16_mem_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,
	mem_wr_if.store   wr_i,
	cpu_acc_if.store  acc_i,
	output byte_t     cpu_rdata_o,
	output logic      cpu_rvalid_o
);

	byte_t             ram [0:RAM_DEPTH-1];
	byte_t             rom [0:ROM_BANKS-1][0:ROM_DEPTH-1];
	logic              cart_lo_q;
	logic              cart_hi_q;
	logic              wr_rom;
	logic              rd_req;
	logic [2:0]        wr_bank;
	logic [2:0]        rd_bank;
	logic [ROM_AW-1:0] rd_rom_addr;
	byte_t             rdata_q;
	logic              rvalid_q;

	assign wr_rom      = wr_i.wr & (wr_i.src != SRC_RAM) & (wr_i.src != SRC_NONE);
	assign wr_bank     = 3'(wr_i.src) - 3'd1;
	assign rd_bank     = 3'(acc_i.src) - 3'd1;
	assign rd_rom_addr = acc_i.addr[ROM_AW-1:0];
	assign rd_req      = acc_i.stb & ~acc_i.we;

	//////////////////////////////
	// Write ports
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (wr_i.wr && wr_i.src == SRC_RAM)
			ram[wr_i.addr] <= wr_i.data;
		// Later assignment gives the CPU priority on a collision
		if (acc_i.stb && acc_i.we)
			ram[acc_i.addr] <= acc_i.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rom)
			rom[wr_bank][wr_i.addr[ROM_AW-1:0]] <= wr_i.data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
		end else if (wr_i.wr) begin
			if (wr_i.src == SRC_CART_LO)
				cart_lo_q <= 1'b1;
			if (wr_i.src == SRC_CART_HI)
				cart_hi_q <= 1'b1;
		end
	end

	//////////////////////////////
	// Registered read
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rd_req) begin
			case (acc_i.src)
				SRC_RAM:     rdata_q <= ram[acc_i.addr];
				SRC_CART_LO: rdata_q <= cart_lo_q ? rom[rd_bank][rd_rom_addr] : OPEN_BUS;
				SRC_CART_HI: rdata_q <= cart_hi_q ? rom[rd_bank][rd_rom_addr] : OPEN_BUS;
				SRC_NONE:    rdata_q <= OPEN_BUS;
				default:     rdata_q <= rom[rd_bank][rd_rom_addr];
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			rvalid_q <= 1'b0;
		else
			rvalid_q <= rd_req;
	end

	assign cpu_rdata_o  = rdata_q;
	assign cpu_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== design/rom_bank_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Model latch, Plus 4 bank register and
// CPU access to memory source decode
//////////////////////////////

module rom_bank_ctrl
	import c16_mem_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire            plus4_i,
	input  wire            cpu_stb_i,
	input  wire            cpu_rnw_i,
	input  wire cpu_sel_t  cpu_sel_i,
	input  wire cpu_addr_t cpu_addr_i,
	input  wire byte_t     cpu_wdata_i,
	cpu_acc_if.driver      acc_o
);

	logic       model_q;
	logic [1:0] lo_sel_q;
	logic [1:0] hi_sel_q;
	logic       bank_wr;
	logic       kern_page;
	mem_src_t   src;

	// Any write into the FDDx page sets the register from the address
	assign bank_wr = model_q & cpu_stb_i & ~cpu_rnw_i &
		(cpu_sel_i == SEL_IO) & (cpu_addr_i[15:4] == BANK_REG_PAGE);

	assign kern_page = (cpu_addr_i[15:8] == KERNAL_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= plus4_i;
			lo_sel_q <= 2'd0;
			hi_sel_q <= 2'd0;
		end else if (bank_wr) begin
			hi_sel_q <= cpu_addr_i[3:2];
			lo_sel_q <= cpu_addr_i[1:0];
		end
	end

	//////////////////////////////
	// Source decode
	//////////////////////////////
	always_comb begin
		src = SRC_NONE;
		case (cpu_sel_i)
			SEL_RAM: src = SRC_RAM;
			SEL_CS0: begin
				case (lo_sel_q)
					2'd0: src = SRC_BASIC;
					2'd1: src = SRC_CART_LO;
					2'd2: src = SRC_FUNC_LO;
					default: src = SRC_NONE;
				endcase
			end
			SEL_CS1: begin
				// Kernal page is always visible
				if (kern_page || hi_sel_q == 2'd0) begin
					src = SRC_KERNAL;
				end else begin
					case (hi_sel_q)
						2'd1: src = SRC_CART_HI;
						2'd2: src = SRC_FUNC_HI;
						default: src = SRC_NONE;
					endcase
				end
			end
			default: src = SRC_NONE;
		endcase
	end

	// Only RAM takes writes
	assign acc_o.stb   = cpu_stb_i & (cpu_rnw_i | (src == SRC_RAM));
	assign acc_o.we    = ~cpu_rnw_i;
	assign acc_o.src   = src;
	assign acc_o.addr  = cpu_addr_i;
	assign acc_o.wdata = cpu_wdata_i;

endmodule

`default_nettype wire

// ==== design/prg_loader.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Download stream loader
// Program files go to RAM, firmware and cartridge
// images to the ROM banks, then BASIC pointer patch
//////////////////////////////

module prg_loader
	import c16_mem_pkg::*;
(
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                dl_active_i,
	input  wire [DL_IDX_W-1:0] dl_index_i,
	input  wire                dl_wr_i,
	input  wire dl_addr_t      dl_addr_i,
	input  wire byte_t         dl_data_i,
	output logic               dl_busy_o,
	mem_wr_if.driver           wr_o
);

	logic      active_q;
	logic [3:0] seq_q;
	logic      busy_q;
	logic      wr_q;
	mem_src_t  src_q;
	cpu_addr_t addr_q;
	byte_t     data_q;
	cpu_addr_t run_addr;
	mem_src_t  rom_src;
	logic [2:0] slot;
	logic      prg_mode;
	logic      prg_done;
	logic      dl_byte;

	assign slot     = dl_addr_i[DL_AW-1:ROM_AW];
	assign prg_mode = (dl_index_i == DL_IDX_PRG);
	assign prg_done = active_q & ~dl_active_i & prg_mode;
	assign dl_byte  = dl_active_i & dl_wr_i;

	// 16 KB slot to ROM bank
	always_comb begin
		rom_src = SRC_NONE;
		case (dl_index_i)
			DL_IDX_ROM: begin
				case (slot)
					3'd1: rom_src = SRC_KERNAL;
					3'd2: rom_src = SRC_BASIC;
					3'd3: rom_src = SRC_FUNC_LO;
					3'd4: rom_src = SRC_FUNC_HI;
					default: rom_src = SRC_NONE;
				endcase
			end
			DL_IDX_CART: begin
				case (slot)
					3'd0: rom_src = SRC_CART_LO;
					3'd1: rom_src = SRC_CART_HI;
					default: rom_src = SRC_NONE;
				endcase
			end
			default: rom_src = SRC_NONE;
		endcase
	end

	//////////////////////////////
	// Control and pointer sequencer
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			seq_q    <= 4'd0;
			busy_q   <= 1'b0;
			wr_q     <= 1'b0;
		end else begin
			active_q <= dl_active_i;
			wr_q     <= 1'b0;
			if (prg_done) begin
				seq_q  <= 4'd1;
				busy_q <= 1'b1;
			end else if (seq_q != 4'd0) begin
				seq_q <= seq_q + 4'd1;
			end else begin
				// Held one extra cycle so the last pointer write lands
				busy_q <= 1'b0;
			end
			if (seq_q[0]) begin
				wr_q <= 1'b1;
			end else if (dl_byte) begin
				if (prg_mode)
					wr_q <= (dl_addr_i > dl_addr_t'(1));
				else
					wr_q <= (rom_src != SRC_NONE);
			end
		end
	end

	//////////////////////////////
	// Write payload and running address
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (seq_q[0]) begin
			src_q  <= SRC_RAM;
			addr_q <= PRG_PTR_ADDR[seq_q[3:1]];
			data_q <= seq_q[1] ? run_addr[15:8] : run_addr[7:0];
		end else if (dl_byte) begin
			if (prg_mode) begin
				// Two-byte little-endian load address first
				if (dl_addr_i == dl_addr_t'(0)) begin
					run_addr[7:0] <= dl_data_i;
				end else if (dl_addr_i == dl_addr_t'(1)) begin
					run_addr[15:8] <= dl_data_i;
				end else begin
					src_q    <= SRC_RAM;
					addr_q   <= run_addr;
					data_q   <= dl_data_i;
					run_addr <= run_addr + cpu_addr_t'(1);
				end
			end else begin
				src_q  <= rom_src;
				addr_q <= CPU_AW'(dl_addr_i[ROM_AW-1:0]);
				data_q <= dl_data_i;
			end
		end
	end

	assign wr_o.wr   = wr_q;
	assign wr_o.src  = src_q;
	assign wr_o.addr = addr_q;
	assign wr_o.data = data_q;
	assign dl_busy_o = busy_q;

endmodule

`default_nettype wire

// ==== design/cpu_acc_if.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Decoded CPU access into the memory store
//////////////////////////////

interface cpu_acc_if
	import c16_mem_pkg::*;
();

	logic      stb;
	logic      we;
	mem_src_t  src;
	cpu_addr_t addr;
	byte_t     wdata;

	// Read data returns one cycle after stb
	modport driver (
		output stb, we, src, addr, wdata
	);

	modport store (
		input  stb, we, src, addr, wdata
	);

endinterface

`default_nettype wire

// ==== design/mem_wr_if.sv ====
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// Loader write port into the memory store
//////////////////////////////

interface mem_wr_if
	import c16_mem_pkg::*;
();

	logic      wr;
	mem_src_t  src;
	cpu_addr_t addr;
	byte_t     data;

	// Write lands on the edge where wr is high
	modport driver (
		output wr, src, addr, data
	);

	modport store (
		input  wr, src, addr, data
	);

endinterface

`default_nettype wire

// ==== design/c16_mem_pkg.sv ====
`default_nettype none
//////////////////////////////
// Shared definitions for the C16/Plus 4 memory core
// Widths, download indices, address constants and
// the chip-select and memory-source types
//////////////////////////////

package c16_mem_pkg;

	localparam int CPU_AW    = 16;
	localparam int DL_AW     = 17;
	localparam int ROM_AW    = 14;
	localparam int DL_IDX_W  = 8;
	localparam int RAM_DEPTH = 1 << CPU_AW;
	localparam int ROM_DEPTH = 1 << ROM_AW;
	localparam int ROM_BANKS = 6;

	typedef logic [7:0]        byte_t;
	typedef logic [CPU_AW-1:0] cpu_addr_t;
	typedef logic [DL_AW-1:0]  dl_addr_t;

	//////////////////////////////
	// Download stream indices
	//////////////////////////////
	localparam logic [DL_IDX_W-1:0] DL_IDX_ROM  = 8'd0;
	localparam logic [DL_IDX_W-1:0] DL_IDX_PRG  = 8'd1;
	localparam logic [DL_IDX_W-1:0] DL_IDX_CART = 8'd2;

	// I/O page of the Plus 4 ROM bank register
	localparam logic [11:0] BANK_REG_PAGE = 12'hFDD;
	localparam logic [7:0]  KERNAL_PAGE   = 8'hFC;
	localparam byte_t       OPEN_BUS      = 8'hFF;

	// BASIC start and end pointers patched after a program load
	localparam cpu_addr_t PRG_PTR_ADDR [0:7] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	typedef enum logic [1:0] {
		SEL_RAM,
		SEL_CS0,
		SEL_CS1,
		SEL_IO
	} cpu_sel_t;

	// ROM banks sit at 1..6 so that bank index is source minus one
	typedef enum logic [2:0] {
		SRC_RAM,
		SRC_KERNAL,
		SRC_BASIC,
		SRC_FUNC_LO,
		SRC_FUNC_HI,
		SRC_CART_LO,
		SRC_CART_HI,
		SRC_NONE
	} mem_src_t;

endpackage

`default_nettype wire
